/* hdl/pmpPkg.sv */
package pmpPkg;

  ////////////////////
  // Entry configuration
  ////////////////////

  // Address matching mode, same encoding as the cfg byte field
  typedef enum logic [1:0] {
    modeOff   = 2'd0,
    modeTor   = 2'd1,
    modeNa4   = 2'd2,
    modeNapot = 2'd3
  } pmpModeE;

  // One cfg byte, bit 7 first
  typedef struct packed {
    logic       lock;
    // Always stored and read as zero
    logic [1:0] reserved;
    pmpModeE    mode;
    logic       x;
    logic       w;
    logic       r;
  } pmpCfgT;

  ////////////////////
  // Access port
  ////////////////////

  // Kind of memory access, picks the needed permission bit
  typedef enum logic [1:0] {
    accRead  = 2'd0,
    accWrite = 2'd1,
    accExec  = 2'd2
  } accTypeE;

  // Attributes that come with each access address
  typedef struct packed {
    // Log2 of the access size in bytes
    logic [1:0] size;
    accTypeE    accType;
    // Machine mode flag
    logic       mMode;
  } pmpAccT;

  typedef struct packed {
    logic fault;
  } pmpRespT;

  // Wishbone word index of the first cfg and first address register
  localparam logic [4:0] cfgBase = 5'd0;
  localparam logic [4:0] adrBase = 5'd16;

endpackage

/* hdl/pmpAdrDec.sv */
`timescale 1ns/10ps

module pmpAdrDec #(
  parameter int paBits = 34
) (
  input  logic              [paBits-1:0] phyAdr,
  input  pmpPkg::pmpCfgT                 cfg,
  input  logic              [paBits-3:0] pmpAdr,
  input  logic                           geIn,
  input  logic                           firstMatch,
  output logic                           geOut,
  output logic                           match,
  output logic              [paBits-1:0] regionTop
);

  // Address register as a byte address
  logic [paBits-1:0] adrFull;
  logic              ltAdr;
  logic              torMatch;
  logic              isNapot;
  logic [paBits-3:0] maskHi;
  logic [paBits-1:0] naMask;
  logic [paBits-1:0] naBase;
  logic              naMatch;
  logic [paBits-1:0] torTop;
  logic [paBits-1:0] naTop;

  assign adrFull = {pmpAdr, 2'b00};

  ////////////////////
  // Top of range
  ////////////////////

  // Unsigned compare, both sides are paBits wide
  assign ltAdr = phyAdr < adrFull;
  // Next entry uses this as the bottom of its range
  assign geOut = ~ltAdr;
  // Inside when at or above the entry below and under this one
  assign torMatch = geIn & ltAdr;

  ////////////////////
  // Naturally aligned
  ////////////////////

  assign isNapot = cfg.mode == pmpPkg::modeNapot;

  // Adding one flips the trailing ones and the lowest zero,
  // so the xor gives a mask of the size bits
  // For NA4 nothing is added and only the low two bits stay masked
  assign maskHi = (pmpAdr + (paBits-2)'(isNapot)) ^ pmpAdr;
  assign naMask = {maskHi, 2'b11};
  assign naBase = adrFull & ~naMask;
  // Upper bits must equal the base, bits inside the region are don't care
  assign naMatch = (phyAdr & ~naMask) == naBase;

  // OFF never matches
  always_comb begin
    case (cfg.mode)
      pmpPkg::modeTor:   match = torMatch;
      pmpPkg::modeNa4:   match = naMatch;
      pmpPkg::modeNapot: match = naMatch;
      default:           match = 1'b0;
    endcase
  end

  ////////////////////
  // Region top
  ////////////////////

  // TOR ends one byte below the byte address of the register
  assign torTop = {pmpAdr - (paBits-2)'(1), 2'b11};
  // Aligned regions end at base with all mask bits set
  assign naTop = naBase | naMask;

  // Only the first matching entry drives a nonzero top
  // The checker ORs all entries together
  assign regionTop = !firstMatch ? '0 :
                     (cfg.mode == pmpPkg::modeTor) ? torTop : naTop;

endmodule

/* hdl/pmpChecker.sv */
`timescale 1ns/10ps

module pmpChecker #(
  parameter int numEntries = 4,
  parameter int paBits     = 34
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   reqValid,
  input  logic            [paBits-1:0]           reqAdr,
  input  pmpPkg::pmpAccT                         reqAcc,
  input  pmpPkg::pmpCfgT  [numEntries-1:0]       cfgs,
  input  logic            [numEntries-1:0][paBits-3:0] adrs,
  output logic                                   respValid,
  output pmpPkg::pmpRespT                        resp
);

  // Greater-or-equal chain, bit 0 is the bottom of memory
  logic [numEntries:0]              geChain;
  logic [numEntries-1:0]            matchVec;
  logic [numEntries-1:0]            firstMatch;
  logic [numEntries-1:0][paBits-1:0] tops;
  logic [paBits-1:0]                regionTop;
  logic [7:0]                       selBits;
  pmpPkg::pmpCfgT                   selCfg;
  logic                             anyMatch;
  logic                             permOk;
  logic                             enforce;
  logic                             overflow;
  logic [2:0]                       sizeSpan;
  logic [paBits:0]                  lastByte;
  pmpPkg::pmpRespT                  respNext;

  assign geChain[0] = 1'b1;

  ////////////////////
  // Per-entry decoders
  ////////////////////

  for (genvar g = 0; g < numEntries; g++) begin : genDec
    pmpAdrDec #(
      .paBits(paBits)
    ) adrDec_i (
      .phyAdr    (reqAdr),
      .cfg       (cfgs[g]),
      .pmpAdr    (adrs[g]),
      .geIn      (geChain[g]),
      .firstMatch(firstMatch[g]),
      .geOut     (geChain[g+1]),
      .match     (matchVec[g]),
      .regionTop (tops[g])
    );
  end

  ////////////////////
  // Priority
  ////////////////////

  // Lowest index wins, later matches are masked off
  always_comb begin : priorityChain
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < numEntries; i++) begin
      firstMatch[i] = matchVec[i] & ~seen;
      seen = seen | matchVec[i];
    end
  end

  // OR half of the distributed mux, decoders supply the AND half
  always_comb begin
    regionTop = '0;
    selBits   = '0;
    for (int i = 0; i < numEntries; i++) begin
      regionTop = regionTop | tops[i];
      selBits   = selBits | (firstMatch[i] ? cfgs[i] : 8'h00);
    end
  end

  assign selCfg   = pmpPkg::pmpCfgT'(selBits);
  assign anyMatch = |matchVec;

  ////////////////////
  // Fault rule
  ////////////////////

  // Permission bit needed for this access kind
  always_comb begin
    case (reqAcc.accType)
      pmpPkg::accRead:  permOk = selCfg.r;
      pmpPkg::accWrite: permOk = selCfg.w;
      pmpPkg::accExec:  permOk = selCfg.x;
      default:          permOk = 1'b0;
    endcase
  end

  // Offset of the last byte touched
  always_comb begin
    case (reqAcc.size)
      2'd0:    sizeSpan = 3'd0;
      2'd1:    sizeSpan = 3'd1;
      2'd2:    sizeSpan = 3'd3;
      default: sizeSpan = 3'd7;
    endcase
  end

  // One extra bit so an access at the top of memory cannot wrap
  assign lastByte = {1'b0, reqAdr} + (paBits+1)'(sizeSpan);
  assign overflow = lastByte > {1'b0, regionTop};

  // Machine mode skips permissions unless the entry is locked
  assign enforce = ~reqAcc.mMode | selCfg.lock;

  // Unmatched accesses fault only outside machine mode
  assign respNext.fault = anyMatch ? ((enforce & ~permOk) | overflow) : ~reqAcc.mMode;

  always_ff @(posedge clk) begin
    if (rst) begin
      respValid <= 1'b0;
    end else begin
      respValid <= reqValid;
    end
  end

  // New result every cycle, meaningful while respValid is high
  always_ff @(posedge clk) begin
    resp <= respNext;
  end

endmodule

/* hdl/pmpCsrFile.sv */
`timescale 1ns/10ps

module pmpCsrFile #(
  parameter int numEntries = 4,
  parameter int paBits     = 34
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   cyc,
  input  logic                                   stb,
  input  logic                                   we,
  input  logic            [4:0]                  adr,
  input  logic            [31:0]                 datW,
  output logic            [31:0]                 datR,
  output logic                                   ack,
  output pmpPkg::pmpCfgT  [numEntries-1:0]       cfgs,
  output logic            [numEntries-1:0][paBits-3:0] adrs
);

  // One past the last index of each register group
  localparam logic [5:0] cfgEnd = 6'(pmpPkg::cfgBase) + 6'(numEntries);
  localparam logic [5:0] adrEnd = 6'(pmpPkg::adrBase) + 6'(numEntries);

  pmpPkg::pmpCfgT [numEntries-1:0]             cfgRegs;
  logic           [numEntries-1:0][paBits-3:0] adrRegs;
  logic                                        accept;
  logic                                        wrEn;
  logic                                        cfgHit;
  logic                                        adrHit;
  logic           [4:0]                        cfgIdx;
  logic           [4:0]                        adrIdx;
  logic           [numEntries-1:0]             cfgSel;
  logic           [numEntries-1:0]             adrSel;
  logic           [numEntries-1:0]             adrLocked;
  pmpPkg::pmpCfgT                              cfgW;
  logic           [31:0]                       rdData;

  ////////////////////
  // Wishbone handshake
  ////////////////////

  // New cycle seen while ack is low
  assign accept = cyc & stb & ~ack;
  assign wrEn   = accept & we;

  // Single-cycle ack, the low cycle after it comes for free
  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= accept;
    end
  end

  // Read data captured at accept, valid while ack is high
  always_ff @(posedge clk) begin
    if (accept) begin
      datR <= rdData;
    end
  end

  ////////////////////
  // Index decode
  ////////////////////

  assign cfgHit = ({1'b0, adr} >= 6'(pmpPkg::cfgBase)) && ({1'b0, adr} < cfgEnd);
  assign adrHit = ({1'b0, adr} >= 6'(pmpPkg::adrBase)) && ({1'b0, adr} < adrEnd);
  assign cfgIdx = adr - pmpPkg::cfgBase;
  assign adrIdx = adr - pmpPkg::adrBase;

  // One-hot entry selects, all zero for unmapped indices
  always_comb begin
    for (int i = 0; i < numEntries; i++) begin
      cfgSel[i] = cfgHit && (cfgIdx == 5'(i));
      adrSel[i] = adrHit && (adrIdx == 5'(i));
    end
  end

  ////////////////////
  // Lock rules
  ////////////////////

  // Address i is frozen by its own lock or by a locked TOR entry above
  for (genvar g = 0; g < numEntries; g++) begin : genLock
    if (g < numEntries - 1) begin : genUpper
      assign adrLocked[g] = cfgRegs[g].lock |
                            (cfgRegs[g+1].lock && cfgRegs[g+1].mode == pmpPkg::modeTor);
    end else begin : genTop
      assign adrLocked[g] = cfgRegs[g].lock;
    end
  end

  // Reserved field forced to zero before storing
  always_comb begin
    cfgW          = pmpPkg::pmpCfgT'(datW[7:0]);
    cfgW.reserved = 2'b00;
  end

  // Write lands on the same edge that raises ack
  always_ff @(posedge clk) begin
    if (rst) begin
      cfgRegs <= '0;
      adrRegs <= '0;
    end else if (wrEn) begin
      for (int i = 0; i < numEntries; i++) begin
        if (cfgSel[i] && !cfgRegs[i].lock) begin
          cfgRegs[i] <= cfgW;
        end
        if (adrSel[i] && !adrLocked[i]) begin
          adrRegs[i] <= datW[paBits-3:0];
        end
      end
    end
  end

  ////////////////////
  // Read mux
  ////////////////////

  // Zero-extended, unmapped reads fall through as zero
  always_comb begin
    rdData = '0;
    for (int i = 0; i < numEntries; i++) begin
      if (cfgSel[i]) begin
        rdData = {24'h000000, cfgRegs[i]};
      end
      if (adrSel[i]) begin
        rdData = 32'(adrRegs[i]);
      end
    end
  end

  assign cfgs = cfgRegs;
  assign adrs = adrRegs;

endmodule

/* hdl/pmpUnit.sv */
`timescale 1ns/10ps

module pmpUnit #(
  parameter int numEntries = 4,
  parameter int paBits     = 34
) (
  input  logic                   clk,
  input  logic                   rst,
  // Wishbone register port
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  logic            [4:0]  adr,
  input  logic            [31:0] datW,
  output logic            [31:0] datR,
  output logic                   ack,
  // Access check port
  input  logic                   reqValid,
  input  logic [paBits-1:0]      reqAdr,
  input  pmpPkg::pmpAccT         reqAcc,
  output logic                   respValid,
  output pmpPkg::pmpRespT        resp
);

  // Register file contents as seen by the checker
  pmpPkg::pmpCfgT [numEntries-1:0]             cfgs;
  logic           [numEntries-1:0][paBits-3:0] adrs;

  ////////////////////
  // Register file
  ////////////////////

  pmpCsrFile #(
    .numEntries(numEntries),
    .paBits    (paBits)
  ) csrFile_i (
    .clk (clk),
    .rst (rst),
    .cyc (cyc),
    .stb (stb),
    .we  (we),
    .adr (adr),
    .datW(datW),
    .datR(datR),
    .ack (ack),
    .cfgs(cfgs),
    .adrs(adrs)
  );

  ////////////////////
  // Checker
  ////////////////////

  pmpChecker #(
    .numEntries(numEntries),
    .paBits    (paBits)
  ) checker_i (
    .clk      (clk),
    .rst      (rst),
    .reqValid (reqValid),
    .reqAdr   (reqAdr),
    .reqAcc   (reqAcc),
    .cfgs     (cfgs),
    .adrs     (adrs),
    .respValid(respValid),
    .resp     (resp)
  );

endmodule

/* tb/pmpTb.sv */
`timescale 1ns/10ps

module pmpTb;

  localparam int    paBits     = 34;
  localparam int    numEntries = 4;
  localparam int    clkPeriod  = 8;
  localparam int    rstCycles  = 16;
  localparam string casesPath  = "tb/pmpCases.txt";

  logic              clk;
  logic              rst;
  logic              cyc;
  logic              stb;
  logic              we;
  logic [4:0]        adr;
  logic [31:0]       datW;
  logic [31:0]       datR;
  logic              ack;
  logic              reqValid;
  logic [paBits-1:0] reqAdr;
  pmpPkg::pmpAccT    reqAcc;
  logic              respValid;
  pmpPkg::pmpRespT   resp;

  // Expected faults in request order
  pmpPkg::pmpRespT expQ[$];
  int              seed = 32'h42ba8e3b;

  pmpUnit dut_i (
    .clk      (clk),
    .rst      (rst),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .datW     (datW),
    .datR     (datR),
    .ack      (ack),
    .reqValid (reqValid),
    .reqAdr   (reqAdr),
    .reqAcc   (reqAcc),
    .respValid(respValid),
    .resp     (resp)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic abortRun();
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic checkData(input logic [31:0] expVal, input logic [31:0] actVal);
    if (actVal !== expVal) begin
      $display("[ERROR] %0t: read data expected %08h, got %08h", $time, expVal, actVal);
      abortRun();
    end
  endtask

  task automatic checkResp(input pmpPkg::pmpRespT expVal, input pmpPkg::pmpRespT actVal);
    if (actVal !== expVal) begin
      $display("[ERROR] %0t: fault expected %0b, got %0b", $time, expVal.fault, actVal.fault);
      abortRun();
    end
  endtask

  task automatic checkValid(input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      $display("[ERROR] %0t: respValid expected %0b, got %0b", $time, expVal, actVal);
      abortRun();
    end
  endtask

  ////////////////////
  // Bus and access drivers
  ////////////////////

  // Ack is looked at on the falling edge where it is stable
  task automatic waitAck();
    do begin
      @(negedge clk);
    end while (ack !== 1'b1);
  endtask

  task automatic busWrite(input logic [4:0] idx, input logic [31:0] data);
    @(posedge clk);
    reqValid <= 1'b0;
    cyc      <= 1'b1;
    stb      <= 1'b1;
    we       <= 1'b1;
    adr      <= idx;
    datW     <= data;
    waitAck();
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic busRead(input logic [4:0] idx, input logic [31:0] expVal);
    @(posedge clk);
    reqValid <= 1'b0;
    cyc      <= 1'b1;
    stb      <= 1'b1;
    we       <= 1'b0;
    adr      <= idx;
    waitAck();
    // datR is only valid while ack is high
    checkData(expVal, datR);
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  // One request per call, consecutive calls give a back-to-back burst
  task automatic issueAccess(input logic [paBits-1:0] a, input pmpPkg::pmpAccT acc,
                             input pmpPkg::pmpRespT expVal);
    @(posedge clk);
    reqValid <= 1'b1;
    reqAdr   <= a;
    reqAcc   <= acc;
    expQ.push_back(expVal);
  endtask

  // Entries are all OFF here, so any address register content is unused
  task automatic fillRandomAdrs();
    logic [31:0] val;
    for (int i = 0; i < numEntries; i++) begin
      val = $random(seed);
      busWrite(pmpPkg::adrBase + 5'(i), val);
      busRead(pmpPkg::adrBase + 5'(i), val);
    end
  endtask

  ////////////////////
  // Response monitor
  ////////////////////

  // respValid must mirror reqValid one cycle late
  initial begin : respMonitor
    logic reqPrev;
    reqPrev = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        checkValid(reqPrev, respValid);
        if (respValid) begin
          checkResp(expQ.pop_front(), resp);
        end
      end
      reqPrev = reqValid;
    end
  end

  // Budget of 40 cycles per cases line plus reset and random fill
  initial begin : watchdog
    int               fd;
    int               lines;
    int               limit;
    logic [8*128-1:0] lineBuf;
    lines = 0;
    fd = $fopen(casesPath, "r");
    if (fd != 0) begin
      while ($fgets(lineBuf, fd) != 0) begin
        lines++;
      end
      $fclose(fd);
    end
    limit = (lines + 2 * numEntries) * 40 + rstCycles;
    #(limit * clkPeriod);
    $display("Run timed out after %0d cycles without finishing the cases", limit);
    abortRun();
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : mainSeq
    int               fd;
    int               code;
    logic [7:0]       op;
    logic [31:0]      idx;
    logic [31:0]      data;
    logic [paBits-1:0] aAdr;
    int               aSize;
    int               aType;
    int               aMode;
    int               aFault;
    logic [8*128-1:0] skipBuf;
    pmpPkg::pmpAccT   acc;
    pmpPkg::pmpRespT  expVal;
    rst      = 1'b1;
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    adr      = '0;
    datW     = '0;
    reqValid = 1'b0;
    reqAdr   = '0;
    reqAcc   = '0;
    repeat (rstCycles) @(posedge clk);
    rst <= 1'b0;
    fillRandomAdrs();
    fd = $fopen(casesPath, "r");
    if (fd == 0) begin
      $display("Could not open the cases file %s", casesPath);
      abortRun();
    end
    code = $fscanf(fd, " %c", op);
    while (code == 1) begin
      if (op == "#") begin
        code = $fgets(skipBuf, fd);
      end else if (op == "W") begin
        code = $fscanf(fd, "%h %h", idx, data);
        busWrite(idx[4:0], data);
      end else if (op == "R") begin
        code = $fscanf(fd, "%h %h", idx, data);
        busRead(idx[4:0], data);
      end else if (op == "A") begin
        code = $fscanf(fd, "%h %d %d %d %d", aAdr, aSize, aType, aMode, aFault);
        acc.size     = aSize[1:0];
        acc.accType  = pmpPkg::accTypeE'(aType[1:0]);
        acc.mMode    = aMode[0];
        expVal.fault = aFault[0];
        issueAccess(aAdr, acc, expVal);
      end else begin
        $display("Unknown operation %c in the cases file", op);
        abortRun();
      end
      code = $fscanf(fd, " %c", op);
    end
    $fclose(fd);
    @(posedge clk);
    reqValid <= 1'b0;
    // Last response lands one cycle after its request
    repeat (2) @(negedge clk);
    if (expQ.size() != 0) begin
      $display("%0d access responses never arrived", expQ.size());
      abortRun();
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

/* tb/pmpCases.txt */
# W idx data | R idx expected data | A addr size type mMode fault
# idx, data and addr in hex; size is log2 of bytes; type 0 read, 1 write, 2 exec
W 01 0000006b
R 01 0000000b
W 11 12345678
R 11 12345678
W 14 deadbeef
R 14 00000000
R 04 00000000
# Entry 0 NA4 at 1000, entry 1 TOR 1000 to 2000, entry 2 NAPOT 4000 to 40ff
W 10 00000400
W 11 00000800
W 12 0000101f
W 00 00000011
W 01 0000000d
W 02 0000001b
A 1800 2 0 0 0
A 1800 2 1 0 1
A 1800 2 2 0 0
A 1ffc 2 0 0 0
A 1ffe 2 0 0 1
A 2000 0 0 0 1
A 0ffc 2 0 0 1
A 0ffc 2 0 1 0
A 1800 2 1 1 0
W 01 0000000a
A 1800 2 0 0 1
A 1800 2 1 0 0
A 1000 2 1 0 1
A 1004 2 1 0 0
A 1000 3 0 0 1
A 40fc 2 1 0 0
A 40fc 3 0 0 1
A 40f8 3 0 0 0
A 40fc 3 0 1 1
A 4100 0 0 0 1
A 4080 0 2 0 1
# Entry 3 locked TOR above entry 2
W 13 00002000
W 03 00000089
W 03 0000000f
R 03 00000089
W 13 00003000
R 13 00002000
W 12 00002000
R 12 0000101f
A 5000 2 1 1 1
A 5000 2 0 1 0
A 7ffc 3 0 1 1
A 4100 2 0 0 0
A 4080 0 2 1 0
A 8000 2 0 1 0
W 00 00000091
W 00 00000013
R 00 00000091
W 10 00000999
R 10 00000400
A 1000 2 1 1 1

/* src.f */
hdl/pmpPkg.sv
hdl/pmpAdrDec.sv
hdl/pmpChecker.sv
hdl/pmpCsrFile.sv
hdl/pmpUnit.sv
tb/pmpTb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps -f src.f --top-module pmpTb -o pmpSim
	out=$$(./obj_dir/pmpSim); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
